//--- hdl/la_defs.svh
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

`define LA_XLEN    32
`define LA_NREG    32
`define LA_RIDX_W  5
`define LA_EXCP_W  16

// Unit types seen by the issue logic
`define LA_TYPE_ALU    4'd0
`define LA_TYPE_BR     4'd1
`define LA_TYPE_DIV    4'd2
`define LA_TYPE_PRIV   4'd3  // CSR, cache ops, traps
`define LA_TYPE_MUL    4'd4
`define LA_TYPE_MEM    4'd5
`define LA_TYPE_ATOM   4'd6  // LL.W and SC.W
`define LA_TYPE_CNT    4'd7  // Timer counter reads
`define LA_TYPE_JLINK  4'd8  // Jumps that write a link register

// ALU operations
`define LA_OP_AND    4'd0
`define LA_OP_OR     4'd1
`define LA_OP_NOR    4'd2
`define LA_OP_XOR    4'd3
`define LA_OP_ADD    4'd4
`define LA_OP_SUB    4'd5
`define LA_OP_SLL    4'd6
`define LA_OP_SRL    4'd7
`define LA_OP_SRA    4'd8
`define LA_OP_SLT    4'd9
`define LA_OP_SLTU   4'd10
`define LA_OP_PASS1  4'd11
`define LA_OP_PASS2  4'd12
`define LA_OP_ADD4   4'd13  // Link value, src1 plus 4

`define LA_PC_BR  2'd1

`endif

//--- hdl/la_pkg.sv
`include "la_defs.svh"

package la_pkg;

    typedef struct packed {
        logic [16:0]             opcode;
        logic [`LA_RIDX_W-1:0]   rk;
        logic [`LA_RIDX_W-1:0]   rj;
        logic [`LA_RIDX_W-1:0]   rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]              opcode;
        logic [11:0]             si12;
        logic [`LA_RIDX_W-1:0]   rj;
        logic [`LA_RIDX_W-1:0]   rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]              opcode;
        logic [19:0]             si20;
        logic [`LA_RIDX_W-1:0]   rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [15:0]             offs16;
        logic [`LA_RIDX_W-1:0]   rj;
        logic [`LA_RIDX_W-1:0]   rd;
    } fmt_2ri16_t;

    // One fetched word, seen through each field layout
    typedef union packed {
        logic [`LA_XLEN-1:0] word;
        fmt_3r_t             fmt_3r;
        fmt_2ri12_t          fmt_2ri12;
        fmt_1ri20_t          fmt_1ri20;
        fmt_2ri16_t          fmt_2ri16;
    } instr_u;

    typedef struct packed {
        logic [3:0] aluop;
        logic [1:0] pcsrc;    // 1 selects the branch target
        logic [1:0] alusrc1;  // 1 selects pc
        logic [1:0] alusrc2;  // 1 selects imm
        logic [3:0] utype;
        logic [4:0] subtype;
        logic       regwrite;
        logic       memwrite;
        logic       memread;
    } ctrl_t;

    typedef struct packed {
        logic [`LA_XLEN-1:0]   pc;
        ctrl_t                 ctrl;
        logic [`LA_RIDX_W-1:0] rd;
        logic [`LA_XLEN-1:0]   src1;
        logic [`LA_XLEN-1:0]   src2;
        logic [`LA_XLEN-1:0]   sdata;  // Store data or second compare value
        logic [`LA_XLEN-1:0]   imm;
        logic [`LA_EXCP_W-1:0] excp_arg;
        logic                  ine;
    } issue_t;

endpackage

//--- hdl/dec_if.sv
`include "la_defs.svh"

interface dec_if;

    la_pkg::ctrl_t          ctrl;
    logic [`LA_RIDX_W-1:0]  rd;
    logic [`LA_XLEN-1:0]    imm;
    logic [`LA_EXCP_W-1:0]  excp_arg;
    logic                   ine;
    logic                   use_rk;  // Second operand from rk instead of rd

    modport dec (
        output ctrl, rd, imm, excp_arg, ine, use_rk
    );

    modport comb (
        input ctrl, rd, imm, excp_arg, ine, use_rk
    );

endinterface

//--- hdl/inst_decoder.sv
`include "la_defs.svh"

module inst_decoder (
    input  la_pkg::instr_u ir,
    dec_if.dec             dec
);

    la_pkg::ctrl_t          ctrl_w;
    logic [`LA_RIDX_W-1:0]  rd_w;
    logic [`LA_XLEN-1:0]    imm_w;
    logic [`LA_EXCP_W-1:0]  excp_w;
    logic                   use_rk_w;
    logic                   ine_w;
    logic                   nop_w;
    logic [`LA_XLEN-1:0]    sext12;
    logic [`LA_XLEN-1:0]    zext12;
    logic [`LA_XLEN-1:0]    offs16;
    logic [`LA_XLEN-1:0]    offs26;
    logic [4:0]             br_sub;

    function automatic la_pkg::ctrl_t unit_ctrl(input logic [3:0] utype, input logic [4:0] sub,
                                                input logic rw, input logic mr, input logic mw);
        la_pkg::ctrl_t c;
        c = '0;
        c.utype = utype;
        c.subtype = sub;
        c.regwrite = rw;
        c.memread = mr;
        c.memwrite = mw;
        return c;
    endfunction

    function automatic la_pkg::ctrl_t alu_ctrl(input logic [3:0] op, input logic use_imm);
        la_pkg::ctrl_t c;
        c = '0;
        c.utype = `LA_TYPE_ALU;
        c.aluop = op;
        c.alusrc2 = {1'b0, use_imm};
        c.regwrite = 1'b1;
        return c;
    endfunction

    function automatic la_pkg::ctrl_t br_ctrl(input logic [3:0] utype, input logic [4:0] sub,
                                              input logic link);
        la_pkg::ctrl_t c;
        c = '0;
        c.utype = utype;
        c.subtype = sub;
        c.pcsrc = `LA_PC_BR;
        if (link)
        begin
            c.aluop = `LA_OP_ADD4;  // pc + 4 into the link register
            c.alusrc1 = 2'd1;
            c.regwrite = 1'b1;
        end
        return c;
    endfunction

    assign sext12 = {{20{ir.fmt_2ri12.si12[11]}}, ir.fmt_2ri12.si12};
    assign zext12 = {20'b0, ir.fmt_2ri12.si12};
    assign offs16 = {{14{ir.fmt_2ri16.offs16[15]}}, ir.fmt_2ri16.offs16, 2'b00};
    assign offs26 = {{4{ir.word[9]}}, ir.word[9:0], ir.fmt_2ri16.offs16, 2'b00};
    assign br_sub = ir.fmt_2ri16.opcode[4:0] - 5'd21;  // BEQ is 1 up to BGEU at 6

    always_comb
    begin
        ctrl_w = '0;
        rd_w = ir.fmt_3r.rd;
        imm_w = '0;
        excp_w = '0;
        use_rk_w = 1'b0;
        ine_w = 1'b0;
        nop_w = 1'b0;
        case (ir.fmt_2ri16.opcode)
            6'b000000:
                case (ir.fmt_2ri12.opcode[3:0])
                    4'b0000:
                    begin
                        use_rk_w = 1'b1;
                        case (ir.fmt_3r.opcode[6:0])
                            7'b0000000:
                            begin
                                use_rk_w = 1'b0;
                                if (ir.fmt_3r.rk[4:1] != 4'b1100)
                                    ine_w = 1'b1;
                                else if (!ir.fmt_3r.rk[0] && ir.fmt_3r.rj != '0)
                                begin
                                    rd_w = ir.fmt_3r.rj;  // RDCNTID.W targets rj
                                    ctrl_w = unit_ctrl(`LA_TYPE_CNT, 5'd0, 1'b1, 1'b0, 1'b0);
                                end
                                else if (!ir.fmt_3r.rk[0] && ir.fmt_3r.rd != '0)
                                    ctrl_w = unit_ctrl(`LA_TYPE_CNT, 5'd1, 1'b1, 1'b0, 1'b0);
                                else if (ir.fmt_3r.rk[0] && ir.fmt_3r.rj == '0)
                                    ctrl_w = unit_ctrl(`LA_TYPE_CNT, 5'd2, 1'b1, 1'b0, 1'b0);
                                else
                                    ine_w = 1'b1;
                            end
                            7'b0100000: ctrl_w = alu_ctrl(`LA_OP_ADD, 1'b0);
                            7'b0100010: ctrl_w = alu_ctrl(`LA_OP_SUB, 1'b0);
                            7'b0100100: ctrl_w = alu_ctrl(`LA_OP_SLT, 1'b0);
                            7'b0100101: ctrl_w = alu_ctrl(`LA_OP_SLTU, 1'b0);
                            7'b0101000: ctrl_w = alu_ctrl(`LA_OP_NOR, 1'b0);
                            7'b0101001: ctrl_w = alu_ctrl(`LA_OP_AND, 1'b0);
                            7'b0101010: ctrl_w = alu_ctrl(`LA_OP_OR, 1'b0);
                            7'b0101011: ctrl_w = alu_ctrl(`LA_OP_XOR, 1'b0);
                            7'b0101110: ctrl_w = alu_ctrl(`LA_OP_SLL, 1'b0);
                            7'b0101111: ctrl_w = alu_ctrl(`LA_OP_SRL, 1'b0);
                            7'b0110000: ctrl_w = alu_ctrl(`LA_OP_SRA, 1'b0);
                            7'b0111000, 7'b0111001, 7'b0111010:  // MUL.W, MULH.W, MULH.WU
                                ctrl_w = unit_ctrl(`LA_TYPE_MUL, {3'b0, ir.word[16:15]},
                                                   1'b1, 1'b0, 1'b0);
                            7'b1000000, 7'b1000001, 7'b1000010, 7'b1000011:  // DIV and MOD
                                ctrl_w = unit_ctrl(`LA_TYPE_DIV, {3'b0, ir.word[16:15]},
                                                   1'b1, 1'b0, 1'b0);
                            7'b1010100, 7'b1010110:
                            begin
                                // BREAK is subtype 11, SYSCALL 12
                                use_rk_w = 1'b0;
                                excp_w = {1'b0, ir.word[14:0]};
                                ctrl_w = unit_ctrl(`LA_TYPE_PRIV, ir.word[16] ? 5'd12 : 5'd11,
                                                   1'b0, 1'b0, 1'b0);
                            end
                            default: ine_w = 1'b1;
                        endcase
                    end
                    4'b0001:
                        if (ir.word[21:20] == 2'b00 && ir.word[17:15] == 3'b001
                            && ir.word[19:18] != 2'b11)
                        begin
                            imm_w = {27'b0, ir.fmt_3r.rk};  // Shift amount
                            ctrl_w = alu_ctrl(`LA_OP_SLL + {2'b00, ir.word[19:18]}, 1'b1);
                        end
                        else
                            ine_w = 1'b1;
                    4'b1000:
                    begin
                        imm_w = sext12;
                        ctrl_w = alu_ctrl(`LA_OP_SLT, 1'b1);
                    end
                    4'b1001:
                    begin
                        imm_w = sext12;
                        ctrl_w = alu_ctrl(`LA_OP_SLTU, 1'b1);
                    end
                    4'b1010:
                    begin
                        imm_w = sext12;
                        ctrl_w = alu_ctrl(`LA_OP_ADD, 1'b1);
                    end
                    4'b1101:
                    begin
                        imm_w = zext12;
                        ctrl_w = alu_ctrl(`LA_OP_AND, 1'b1);
                    end
                    4'b1110:
                    begin
                        imm_w = zext12;
                        ctrl_w = alu_ctrl(`LA_OP_OR, 1'b1);
                    end
                    4'b1111:
                    begin
                        imm_w = zext12;
                        ctrl_w = alu_ctrl(`LA_OP_XOR, 1'b1);
                    end
                    default: ine_w = 1'b1;
                endcase
            6'b000001:
                if (ir.word[25:24] == 2'b00)
                begin
                    // CSRRD when rj is 0, CSRWR when 1, CSRXCHG otherwise
                    excp_w = {2'b00, ir.word[23:10]};
                    ctrl_w = unit_ctrl(`LA_TYPE_PRIV,
                                       (ir.fmt_3r.rj == 5'd0) ? 5'd8 :
                                       (ir.fmt_3r.rj == 5'd1) ? 5'd9 : 5'd10,
                                       1'b1, 1'b0, 1'b0);
                end
                else if (ir.word[25:22] == 4'b1000)
                begin
                    imm_w = sext12;  // CACOP
                    excp_w = {11'b0, ir.fmt_3r.rd};
                    ctrl_w = unit_ctrl(`LA_TYPE_PRIV, 5'd0, 1'b0, 1'b0, 1'b0);
                end
                else if (ir.word[25:15] == 11'b10010010000
                         && ir.word[14:0] == 15'b011100000000000)
                    ctrl_w = unit_ctrl(`LA_TYPE_PRIV, 5'd6, 1'b0, 1'b0, 1'b0);  // ERTN
                else if (ir.word[25:15] == 11'b10010010001)
                begin
                    excp_w = {1'b0, ir.word[14:0]};  // IDLE level
                    ctrl_w = unit_ctrl(`LA_TYPE_PRIV, 5'd7, 1'b0, 1'b0, 1'b0);
                end
                else
                    ine_w = 1'b1;  // TLB ops land here too
            6'b000101, 6'b000111:
                if (!ir.fmt_1ri20.opcode[0])
                begin
                    imm_w = {ir.fmt_1ri20.si20, 12'b0};
                    if (ir.word[27])
                    begin
                        ctrl_w = alu_ctrl(`LA_OP_ADD, 1'b1);  // PCADDU12I
                        ctrl_w.alusrc1 = 2'd1;
                    end
                    else
                        ctrl_w = alu_ctrl(`LA_OP_PASS2, 1'b1);  // LU12I.W
                end
                else
                    ine_w = 1'b1;
            6'b001000:
            begin
                imm_w = {{16{ir.word[23]}}, ir.word[23:10], 2'b00};
                case (ir.word[25:24])
                    2'b00: ctrl_w = unit_ctrl(`LA_TYPE_ATOM, 5'd0, 1'b1, 1'b1, 1'b0);
                    2'b01: ctrl_w = unit_ctrl(`LA_TYPE_ATOM, 5'd1, 1'b1, 1'b0, 1'b1);
                    default: ine_w = 1'b1;
                endcase
            end
            6'b001010:
            begin
                imm_w = sext12;
                case (ir.fmt_2ri12.opcode[3:0])
                    4'b0000, 4'b0001, 4'b0010:  // LD.B, LD.H, LD.W
                        ctrl_w = unit_ctrl(`LA_TYPE_MEM, {3'b0, ir.word[23:22]},
                                           1'b1, 1'b1, 1'b0);
                    4'b0100, 4'b0101, 4'b0110:  // ST.B, ST.H, ST.W
                        ctrl_w = unit_ctrl(`LA_TYPE_MEM, 5'd3 + {3'b0, ir.word[23:22]},
                                           1'b0, 1'b0, 1'b1);
                    4'b1000, 4'b1001:  // LD.BU, LD.HU
                        ctrl_w = unit_ctrl(`LA_TYPE_MEM, 5'd6 + {4'b0, ir.word[22]},
                                           1'b1, 1'b1, 1'b0);
                    4'b1011: nop_w = 1'b1;  // PRELD
                    default: ine_w = 1'b1;
                endcase
            end
            6'b001110:
                if (ir.word[25:16] == 10'b0001110010)
                begin
                    if (ir.word[15])
                        ctrl_w = unit_ctrl(`LA_TYPE_MEM, 5'd8, 1'b0, 1'b0, 1'b0);  // IBAR
                    else
                        nop_w = 1'b1;  // DBAR
                end
                else
                    ine_w = 1'b1;
            6'b010011:
            begin
                imm_w = offs16;  // JIRL
                ctrl_w = br_ctrl(`LA_TYPE_JLINK, 5'd0, 1'b1);
            end
            6'b010100:
            begin
                imm_w = offs26;  // B
                ctrl_w = br_ctrl(`LA_TYPE_BR, 5'd0, 1'b0);
            end
            6'b010101:
            begin
                imm_w = offs26;  // BL
                rd_w = 5'd1;
                ctrl_w = br_ctrl(`LA_TYPE_JLINK, 5'd1, 1'b1);
            end
            6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
            begin
                imm_w = offs16;
                ctrl_w = br_ctrl(`LA_TYPE_BR, br_sub, 1'b0);
            end
            default: ine_w = 1'b1;
        endcase
    end

    assign dec.ctrl = (ine_w || nop_w) ? '0 : ctrl_w;
    assign dec.rd = rd_w;
    assign dec.imm = imm_w;
    assign dec.excp_arg = excp_w;
    assign dec.ine = ine_w;
    assign dec.use_rk = use_rk_w;

endmodule

//--- hdl/reg_file.sv
`include "la_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`LA_RIDX_W-1:0] raddr_j,
    input  logic [`LA_RIDX_W-1:0] raddr_k,
    input  logic [`LA_RIDX_W-1:0] raddr_d,
    output logic [`LA_XLEN-1:0]   rdata_j,
    output logic [`LA_XLEN-1:0]   rdata_k,
    output logic [`LA_XLEN-1:0]   rdata_d,
    input  logic                  wb_en,
    input  logic [`LA_RIDX_W-1:0] wb_addr,
    input  logic [`LA_XLEN-1:0]   wb_data
);

    logic [`LA_XLEN-1:0] regs [1:`LA_NREG-1];  // r0 has no storage

    function automatic logic [`LA_XLEN-1:0] read_port(input logic [`LA_RIDX_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb_en && wb_addr == addr)
            return wb_data;  // Write-through
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < `LA_NREG; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_addr != '0)
            regs[wb_addr] <= wb_data;
    end

    always_comb
    begin
        rdata_j = read_port(raddr_j);
        rdata_k = read_port(raddr_k);
        rdata_d = read_port(raddr_d);
    end

endmodule

//--- hdl/operand_stage.sv
`include "la_defs.svh"

module operand_stage (
    input  logic                clk,
    input  logic                arst_n,
    dec_if.comb                 dec,
    input  logic [`LA_XLEN-1:0] in_pc,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`LA_XLEN-1:0] rdata_j,
    input  logic [`LA_XLEN-1:0] rdata_k,
    input  logic [`LA_XLEN-1:0] rdata_d,
    input  logic                out_ready,
    output logic                out_valid,
    output la_pkg::issue_t      issue
);

    la_pkg::issue_t next_w;
    logic           accept;

    // Slot takes a new entry when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;

    always_comb
    begin
        next_w.pc = in_pc;
        next_w.ctrl = dec.ctrl;
        next_w.rd = dec.rd;
        next_w.src1 = (dec.ctrl.alusrc1 == 2'd1) ? in_pc : rdata_j;
        if (dec.ctrl.alusrc2 == 2'd1)
            next_w.src2 = dec.imm;
        else if (dec.use_rk)
            next_w.src2 = rdata_k;
        else
            next_w.src2 = rdata_d;  // Branch compare and 2RI ops
        next_w.sdata = rdata_d;
        next_w.imm = dec.imm;
        next_w.excp_arg = dec.excp_arg;
        next_w.ine = dec.ine;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            issue <= next_w;  // Held while stalled
    end

endmodule

//--- hdl/decode_top.sv
`include "la_defs.svh"

module decode_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [`LA_XLEN-1:0]          in_pc,
    input  logic [`LA_XLEN-1:0]          in_ir,
    input  logic                         wb_en,
    input  logic [`LA_RIDX_W-1:0]        wb_addr,
    input  logic [`LA_XLEN-1:0]          wb_data,
    input  logic                         out_ready,
    output logic                         out_valid,
    output logic [`LA_XLEN-1:0]          out_pc,
    output logic [$bits(la_pkg::ctrl_t)-1:0] out_ctrl,
    output logic [`LA_RIDX_W-1:0]        out_rd,
    output logic [`LA_XLEN-1:0]          out_src1,
    output logic [`LA_XLEN-1:0]          out_src2,
    output logic [`LA_XLEN-1:0]          out_sdata,
    output logic [`LA_XLEN-1:0]          out_imm,
    output logic [`LA_EXCP_W-1:0]        out_excp_arg,
    output logic                         out_ine
);

    dec_if                 dec_bus ();
    logic [`LA_XLEN-1:0]   rdata_j;
    logic [`LA_XLEN-1:0]   rdata_k;
    logic [`LA_XLEN-1:0]   rdata_d;
    la_pkg::issue_t        issue;

    inst_decoder i_dec (
        .ir  (in_ir),
        .dec (dec_bus)
    );

    // Raw fields, read alongside the decoder
    reg_file i_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_j (in_ir[9:5]),
        .raddr_k (in_ir[14:10]),
        .raddr_d (in_ir[4:0]),
        .rdata_j (rdata_j),
        .rdata_k (rdata_k),
        .rdata_d (rdata_d),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    operand_stage i_ops (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec       (dec_bus),
        .in_pc     (in_pc),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .rdata_j   (rdata_j),
        .rdata_k   (rdata_k),
        .rdata_d   (rdata_d),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .issue     (issue)
    );

    assign out_pc = issue.pc;
    assign out_ctrl = issue.ctrl;
    assign out_rd = issue.rd;
    assign out_src1 = issue.src1;
    assign out_src2 = issue.src2;
    assign out_sdata = issue.sdata;
    assign out_imm = issue.imm;
    assign out_excp_arg = issue.excp_arg;
    assign out_ine = issue.ine;

endmodule

//--- tests/tb_decode_top.sv
`include "la_defs.svh"

module tb_decode_top;

    localparam int PERIOD = 40;
    localparam int MAX_LINES = 64;

    logic                             clk;
    logic                             arst_n;
    logic                             in_valid;
    logic                             in_ready;
    logic [`LA_XLEN-1:0]              in_pc;
    logic [`LA_XLEN-1:0]              in_ir;
    logic                             wb_en;
    logic [`LA_RIDX_W-1:0]            wb_addr;
    logic [`LA_XLEN-1:0]              wb_data;
    logic                             out_ready;
    logic                             out_valid;
    logic [`LA_XLEN-1:0]              out_pc;
    logic [$bits(la_pkg::ctrl_t)-1:0] out_ctrl;
    logic [`LA_RIDX_W-1:0]            out_rd;
    logic [`LA_XLEN-1:0]              out_src1;
    logic [`LA_XLEN-1:0]              out_src2;
    logic [`LA_XLEN-1:0]              out_sdata;
    logic [`LA_XLEN-1:0]              out_imm;
    logic [`LA_EXCP_W-1:0]            out_excp_arg;
    logic                             out_ine;

    byte         kind [MAX_LINES];
    logic [31:0] fld [MAX_LINES][11];  // W uses columns 0 to 2
    int          n_lines = 0;
    int          n_instr = 0;
    int          matched = 0;
    int          cur_line = 0;
    logic        loaded = 1'b0;
    logic        stress = 1'b0;  // Random out_ready when set
    logic [31:0] rnd;
    int          exp_q [$];  // Line numbers of accepted instructions

    decode_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_ir        (in_ir),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_ctrl     (out_ctrl),
        .out_rd       (out_rd),
        .out_src1     (out_src1),
        .out_src2     (out_src2),
        .out_sdata    (out_sdata),
        .out_imm      (out_imm),
        .out_excp_arg (out_excp_arg),
        .out_ine      (out_ine)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v [11];
        v = '{default: '0};
        fd = $fopen("tests/decode_tests.txt", "r");
        if (fd == 0)
            fail_run("could not open the test file tests/decode_tests.txt");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 0 && (line[0] == "W" || line[0] == "I"))
            begin
                if (line[0] == "W")
                    cnt = $sscanf(line, "W %h %h %h", v[0], v[1], v[2]) + 8;
                else
                    cnt = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                                  v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                if (cnt != 11 || n_lines == MAX_LINES)
                    fail_run($sformatf("bad or surplus line in the test file: %s", line));
                kind[n_lines] = line[0];
                for (int j = 0; j < 11; j++)
                    fld[n_lines][j] = v[j];
                if (line[0] == "I")
                    n_instr++;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    // Holds the instruction until the DUT takes it
    task automatic send_instr(input int idx);
        in_valid = 1'b1;
        in_pc = fld[idx][0];
        in_ir = fld[idx][1];
        cur_line = idx;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
    endtask

    task automatic run_pass();
        for (int i = 0; i < n_lines; i++)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            wb_en = 1'b0;
            if (kind[i] == "W")
            begin
                wb_en = 1'b1;
                wb_addr = fld[i][0][`LA_RIDX_W-1:0];
                wb_data = fld[i][1];
                if (fld[i][2] != 0)
                begin
                    i++;  // Write lands in the same cycle as this instruction
                    send_instr(i);
                end
            end
            else
                send_instr(i);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wb_en = 1'b0;
    endtask

    task automatic compare_output();
        int idx;
        if (exp_q.size() == 0)
            fail_run("an output transfer happened with no instruction outstanding");
        idx = exp_q.pop_front();
        check_value("pc", out_pc, fld[idx][2]);
        check_value("ctrl", 32'(out_ctrl), fld[idx][3]);
        check_value("rd", 32'(out_rd), fld[idx][4]);
        check_value("src1", out_src1, fld[idx][5]);
        check_value("src2", out_src2, fld[idx][6]);
        check_value("sdata", out_sdata, fld[idx][7]);
        check_value("imm", out_imm, fld[idx][8]);
        check_value("excp_arg", 32'(out_excp_arg), fld[idx][9]);
        check_value("ine", 32'(out_ine), fld[idx][10]);
        matched++;
    endtask

    // Scoreboard sees both handshakes at the rising edge
    always @(posedge clk)
    begin
        if (arst_n && in_valid && in_ready)
            exp_q.push_back(cur_line);
        if (arst_n && out_valid && out_ready)
            compare_output();
    end

    initial
    begin
        void'($urandom(32'h8d38773f));
        forever
        begin
            @(negedge clk);
            if (stress)
            begin
                rnd = $urandom();
                out_ready = rnd[0];
            end
            else
                out_ready = 1'b1;
        end
    end

    initial
    begin
        int time_limit;
        wait (loaded);
        // Two passes with up to four cycles a line under back-pressure
        time_limit = n_lines * 2 * 4 * PERIOD + 8 * PERIOD + 2000;
        #(time_limit);
        fail_run("timeout: outputs stopped arriving before every instruction was checked");
    end

    initial
    begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_ir = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        out_ready = 1'b1;
        load_tests();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        run_pass();
        @(posedge clk);
        stress = 1'b1;
        run_pass();  // Same lines again under random out_ready
        @(posedge clk);
        stress = 1'b0;
        while (matched < 2 * n_instr)
            @(posedge clk);
        @(negedge clk);
        if (matched == 2 * n_instr && exp_q.size() == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            fail_run("instructions were accepted but never came out of the stage");
    end

endmodule

//--- tests/decode_tests.txt
# W addr data with_next (1: write in the same cycle as the next I line), all hex
# I pc ir then expected pc ctrl rd src1 src2 sdata imm excp_arg ine, all hex
W 01 11111111 0
W 02 0000002a 0
W 03 33333333 0
W 04 00001234 0
W 05 fffffff0 0
W 06 80000001 0
W 07 7fffffff 0
I 1c000000 00101483 1c000000 100004 03 00001234 fffffff0 33333333 00000000 0000 0
I 1c000004 00111cc2 1c000004 140004 02 80000001 7fffffff 0000002a 00000000 0000 0
I 1c000008 001210a1 1c000008 240004 01 fffffff0 00001234 11111111 00000000 0000 0
I 1c00000c 00148c27 1c00000c 000004 07 11111111 33333333 7fffffff 00000000 0000 0
I 1c000010 00159844 1c000010 0c0004 04 0000002a 80000001 00001234 00000000 0000 0
I 1c000014 023ff482 1c000014 241004 02 00001234 fffffffd 0000002a fffffffd 0000 0
I 1c000018 02a000e3 1c000018 101004 03 7fffffff fffff800 33333333 fffff800 0000 0
I 1c00001c 037c3cc5 1c00001c 001004 05 80000001 00000f0f fffffff0 00000f0f 0000 0
I 1c000020 03a6ac41 1c000020 041004 01 0000002a 000009ab 11111111 000009ab 0000 0
I 1c000024 15000026 1c000024 301004 06 11111111 80001000 80000001 80001000 0000 0
I 1c000028 1c000247 1c000028 105004 07 1c000028 00012000 7fffffff 00012000 0000 0
I 1c00002c 58004085 1c00002c 010108 05 00001234 fffffff0 fffffff0 00000040 0000 0
I 1c000030 6ffff8c7 1c000030 010130 07 80000001 7fffffff 7fffffff fffffff8 0000 0
I 1c000034 54040043 1c000034 35480c 01 1c000034 33333333 33333333 010c0400 0000 0
I 1c000038 4c0010c2 1c000038 354804 02 1c000038 0000002a 0000002a 00000010 0000 0
I 1c00003c fc0000e5 1c00003c 000000 05 7fffffff fffffff0 fffffff0 00000000 0000 1
I 1c000040 2ac04060 1c000040 000000 00 33333333 00000000 00000000 00000010 0000 0
I 1c000044 38720003 1c000044 000000 03 00000000 33333333 33333333 00000000 0000 0
I 1c000048 002b0025 1c000048 000360 05 11111111 fffffff0 fffffff0 00000000 0025 0
I 1c00004c 002a0c62 1c00004c 000358 02 33333333 0000002a 0000002a 00000000 0c62 0
I 1c000050 04003004 1c000050 000344 04 00000000 00001234 00001234 00000000 000c 0
W 05 deadbeef 1
I 1c000054 001000a6 1c000054 100004 06 deadbeef 00000000 80000001 00000000 0000 0
W 00 12345678 0
I 1c000058 00100000 1c000058 100004 00 00000000 00000000 00000000 00000000 0000 0

//--- src.f
+incdir+hdl
hdl/la_pkg.sv
hdl/dec_if.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_stage.sv
hdl/decode_top.sv
tests/tb_decode_top.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, then judge the log
verilator --binary --timing --top-module tb_decode_top -f src.f -o sim_decode \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_decode > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
